// ==== design/cache_event_pkg.sv ====
package cache_event_pkg;

	// counter and stamp widths
	typedef logic [63:0] event_count_t;            // one event counter
	typedef logic [47:0] ref_stamp_t;              // reference count used as time stamp

	// eviction status codes
	typedef logic [1:0] evict_status_t;

	localparam evict_status_t EVICT_SINGLE = 2'b01; // one expired lease
	localparam evict_status_t EVICT_MULTI  = 2'b10; // several leases expired
	localparam evict_status_t EVICT_RANDOM = 2'b11; // no expired line, random victim

	// trace buffer geometry
	localparam int TRACE_DEPTH = 8;                 // must stay a power of two
	localparam int TRACE_PTR_W = $clog2(TRACE_DEPTH);

	typedef logic [TRACE_PTR_W-1:0] trace_ptr_t;    // read and write pointers
	typedef logic [3:0]             trace_count_t;  // occupancy, 0 to TRACE_DEPTH

endpackage

// ==== design/perf_map_pkg.sv ====
package perf_map_pkg;

	// record selected by comm bits 27:26, codes 2 and 3 are both reserved
	typedef enum logic [1:0] {
		REC_STATS    = 2'd0,
		REC_EVICT    = 2'd1,
		REC_RESERVED = 2'd2
	} record_sel_t;

	typedef logic [4:0] read_addr_t;                // comm bits 4:0

	// configuration word fields
	localparam int COMM_COUNT_EN_BIT = 24;
	localparam int COMM_POP_BIT      = 25;
	localparam int COMM_REC_LO       = 26;
	localparam int COMM_REC_HI       = 27;

	localparam logic [31:0] CACHE_ID = 32'h4c32_4c43; // "L2LC"

	// statistics record, low and high word of each counter
	localparam read_addr_t ADDR_HITS_LO       = 5'd0;
	localparam read_addr_t ADDR_HITS_HI       = 5'd1;
	localparam read_addr_t ADDR_MISSES_LO     = 5'd2;
	localparam read_addr_t ADDR_MISSES_HI     = 5'd3;
	localparam read_addr_t ADDR_WB_LO         = 5'd4;
	localparam read_addr_t ADDR_WB_HI         = 5'd5;
	localparam read_addr_t ADDR_CYCLES_LO     = 5'd6;
	localparam read_addr_t ADDR_CYCLES_HI     = 5'd7;
	localparam read_addr_t ADDR_EXPIRED_LO    = 5'd8;
	localparam read_addr_t ADDR_EXPIRED_HI    = 5'd9;
	localparam read_addr_t ADDR_DEFAULTED_LO  = 5'd10;
	localparam read_addr_t ADDR_DEFAULTED_HI  = 5'd11;
	localparam read_addr_t ADDR_MULTI_LO      = 5'd12;
	localparam read_addr_t ADDR_MULTI_HI      = 5'd13;
	localparam read_addr_t ADDR_CACHE_ID      = 5'd15;
	localparam read_addr_t ADDR_DEF_MISS_LO   = 5'd16;
	localparam read_addr_t ADDR_DEF_MISS_HI   = 5'd17;
	localparam read_addr_t ADDR_RAND_EVICT_LO = 5'd18;
	localparam read_addr_t ADDR_RAND_EVICT_HI = 5'd19;

	// eviction record
	localparam read_addr_t EV_ADDR_STATUS   = 5'd0; // status 1:0, occupancy 11:8
	localparam read_addr_t EV_ADDR_STAMP_LO = 5'd1;
	localparam read_addr_t EV_ADDR_STAMP_HI = 5'd2; // upper 16 stamp bits
	localparam read_addr_t EV_ADDR_FULL     = 5'd3;

endpackage

// ==== design/perf_control.sv ====
module perf_control (
	input  logic                      clock_i,
	input  logic                      resetn_i,
	input  logic [31:0]               comm_i,       // configuration word
	output logic                      count_en_o,
	output logic                      track_en_o,
	output logic                      pop_o,        // one pulse per rising pop bit
	output perf_map_pkg::record_sel_t record_o,
	output perf_map_pkg::read_addr_t  addr_o
);
	import perf_map_pkg::*;

	logic        pop_bit_q;                           // pop bit of the last cycle
	logic        pop_bit;
	record_sel_t record_d;

	assign pop_bit = comm_i[COMM_POP_BIT];

	// fold both reserved codes onto one value
	always_comb begin
		case (comm_i[COMM_REC_HI:COMM_REC_LO])
			2'd0: begin
				record_d = REC_STATS;
			end
			2'd1: begin
				record_d = REC_EVICT;
			end
			default: begin
				record_d = REC_RESERVED;
			end
		endcase
	end

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			count_en_o <= 1'b0;
			track_en_o <= 1'b0;
			pop_o      <= 1'b0;
			pop_bit_q  <= 1'b0;
			record_o   <= REC_STATS;
			addr_o     <= '0;
		end else begin
			count_en_o <= comm_i[COMM_COUNT_EN_BIT];
			track_en_o <= (record_d == REC_EVICT);  // tracker runs only on its own record
			record_o   <= record_d;
			addr_o     <= comm_i[$bits(read_addr_t)-1:0];
			pop_bit_q  <= pop_bit;
			pop_o      <= pop_bit & ~pop_bit_q;     // held bit pops once
		end
	end

endmodule

// ==== design/event_counters.sv ====
module event_counters (
	input  logic                        clock_i,
	input  logic                        resetn_i,
	input  logic                        count_en_i,
	input  logic                        req_i,
	input  logic                        hit_i,
	input  logic                        miss_i,
	input  logic                        writeback_i,
	input  logic                        expired_i,
	input  logic                        expired_multi_i,
	input  logic                        defaulted_i,
	input  logic                        rand_evict_i,
	output cache_event_pkg::event_count_t hits_o,
	output cache_event_pkg::event_count_t misses_o,
	output cache_event_pkg::event_count_t writebacks_o,
	output cache_event_pkg::event_count_t cycles_o,
	output cache_event_pkg::event_count_t expired_o,
	output cache_event_pkg::event_count_t multi_expired_o,
	output cache_event_pkg::event_count_t defaulted_o,
	output cache_event_pkg::event_count_t default_misses_o,
	output cache_event_pkg::event_count_t rand_evict_o,
	output cache_event_pkg::ref_stamp_t   ref_stamp_o
);

	logic default_miss;

	// a miss that also got a default lease
	assign default_miss = miss_i & defaulted_i;

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			hits_o           <= '0;
			misses_o         <= '0;
			writebacks_o     <= '0;
			cycles_o         <= '0;
			expired_o        <= '0;
			multi_expired_o  <= '0;
			defaulted_o      <= '0;
			default_misses_o <= '0;
			rand_evict_o     <= '0;
			ref_stamp_o      <= '0;
		end else if (count_en_i) begin
			cycles_o <= cycles_o + 1'b1;                 // enabled cycles
			if (req_i) begin
				ref_stamp_o <= ref_stamp_o + 1'b1;       // one tick per reference
			end
			if (hit_i) begin
				hits_o <= hits_o + 1'b1;
			end
			if (miss_i) begin
				misses_o <= misses_o + 1'b1;
			end
			if (writeback_i) begin
				writebacks_o <= writebacks_o + 1'b1;
			end
			if (expired_i) begin
				expired_o <= expired_o + 1'b1;
			end
			if (expired_multi_i) begin
				multi_expired_o <= multi_expired_o + 1'b1;
			end
			if (defaulted_i) begin
				defaulted_o <= defaulted_o + 1'b1;
			end
			if (default_miss) begin
				default_misses_o <= default_misses_o + 1'b1;
			end
			if (rand_evict_i) begin
				rand_evict_o <= rand_evict_o + 1'b1;
			end
		end
	end

endmodule

// ==== design/eviction_tracker.sv ====
module eviction_tracker (
	input  logic                          clock_i,
	input  logic                          resetn_i,
	input  logic                          track_en_i,
	input  logic                          pop_i,
	input  logic                          expired_i,
	input  logic                          expired_multi_i,
	input  logic                          rand_evict_i,
	input  cache_event_pkg::ref_stamp_t    ref_stamp_i,   // count before this edge's increment
	output cache_event_pkg::evict_status_t head_status_o,
	output cache_event_pkg::ref_stamp_t    head_stamp_o,
	output cache_event_pkg::trace_count_t  count_o,
	output logic                          full_o
);
	import cache_event_pkg::*;

	evict_status_t status_mem [TRACE_DEPTH];
	ref_stamp_t    stamp_mem  [TRACE_DEPTH];

	trace_ptr_t    wr_ptr_q;
	trace_ptr_t    rd_ptr_q;
	trace_count_t  count_q;
	evict_status_t status_d;
	logic          any_evict;
	logic          empty;
	logic          push;
	logic          pop;

	// multi wins over random, random over single
	always_comb begin
		if (expired_multi_i) begin
			status_d = EVICT_MULTI;
		end else if (rand_evict_i) begin
			status_d = EVICT_RANDOM;
		end else if (expired_i) begin
			status_d = EVICT_SINGLE;
		end else begin
			status_d = '0;
		end
	end

	assign any_evict = expired_i | expired_multi_i | rand_evict_i;
	assign empty     = (count_q == '0);
	assign full_o    = (count_q == trace_count_t'(TRACE_DEPTH));
	assign push      = track_en_i & any_evict & ~full_o; // events are dropped while full
	assign pop       = pop_i & ~empty;

	always_ff @(posedge clock_i) begin
		if (push) begin
			status_mem[wr_ptr_q] <= status_d;
			stamp_mem[wr_ptr_q]  <= ref_stamp_i;
		end
	end

	// pointers wrap on their own since the depth is a power of two
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			if (push) begin
				wr_ptr_q <= wr_ptr_q + 1'b1;
			end
			if (pop) begin
				rd_ptr_q <= rd_ptr_q + 1'b1;
			end
			case ({push, pop})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;         // idle or push with pop
			endcase
		end
	end

	assign head_status_o = empty ? '0 : status_mem[rd_ptr_q];
	assign head_stamp_o  = empty ? '0 : stamp_mem[rd_ptr_q];
	assign count_o       = count_q;

endmodule

// ==== design/perf_readout.sv ====
module perf_readout (
	input  logic                          clock_i,
	input  logic                          resetn_i,
	input  perf_map_pkg::record_sel_t      record_i,
	input  perf_map_pkg::read_addr_t       addr_i,
	input  cache_event_pkg::event_count_t  hits_i,
	input  cache_event_pkg::event_count_t  misses_i,
	input  cache_event_pkg::event_count_t  writebacks_i,
	input  cache_event_pkg::event_count_t  cycles_i,
	input  cache_event_pkg::event_count_t  expired_i,
	input  cache_event_pkg::event_count_t  multi_expired_i,
	input  cache_event_pkg::event_count_t  defaulted_i,
	input  cache_event_pkg::event_count_t  default_misses_i,
	input  cache_event_pkg::event_count_t  rand_evict_i,
	input  cache_event_pkg::evict_status_t head_status_i,
	input  cache_event_pkg::ref_stamp_t    head_stamp_i,
	input  cache_event_pkg::trace_count_t  count_i,
	input  logic                          full_i,
	output logic [31:0]                   comm_o,
	output logic                          stall_o
);
	import perf_map_pkg::*;

	logic [31:0] stats_word;
	logic [31:0] evict_word;
	logic [31:0] read_word;

	always_comb begin
		case (addr_i)
			ADDR_HITS_LO:       stats_word = hits_i[31:0];
			ADDR_HITS_HI:       stats_word = hits_i[63:32];
			ADDR_MISSES_LO:     stats_word = misses_i[31:0];
			ADDR_MISSES_HI:     stats_word = misses_i[63:32];
			ADDR_WB_LO:         stats_word = writebacks_i[31:0];
			ADDR_WB_HI:         stats_word = writebacks_i[63:32];
			ADDR_CYCLES_LO:     stats_word = cycles_i[31:0];
			ADDR_CYCLES_HI:     stats_word = cycles_i[63:32];
			ADDR_EXPIRED_LO:    stats_word = expired_i[31:0];
			ADDR_EXPIRED_HI:    stats_word = expired_i[63:32];
			ADDR_DEFAULTED_LO:  stats_word = defaulted_i[31:0];
			ADDR_DEFAULTED_HI:  stats_word = defaulted_i[63:32];
			ADDR_MULTI_LO:      stats_word = multi_expired_i[31:0];
			ADDR_MULTI_HI:      stats_word = multi_expired_i[63:32];
			ADDR_CACHE_ID:      stats_word = CACHE_ID;
			ADDR_DEF_MISS_LO:   stats_word = default_misses_i[31:0];
			ADDR_DEF_MISS_HI:   stats_word = default_misses_i[63:32];
			ADDR_RAND_EVICT_LO: stats_word = rand_evict_i[31:0];
			ADDR_RAND_EVICT_HI: stats_word = rand_evict_i[63:32];
			default:            stats_word = '0;      // unmapped
		endcase
	end

	always_comb begin
		case (addr_i)
			EV_ADDR_STATUS:   evict_word = {20'd0, count_i, 6'd0, head_status_i};
			EV_ADDR_STAMP_LO: evict_word = head_stamp_i[31:0];
			EV_ADDR_STAMP_HI: evict_word = {16'd0, head_stamp_i[47:32]};
			EV_ADDR_FULL:     evict_word = {31'd0, full_i};
			default:          evict_word = '0;
		endcase
	end

	assign read_word = (record_i == REC_STATS) ? stats_word :
	                   (record_i == REC_EVICT) ? evict_word : '0; // reserved reads zero

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			comm_o <= '0;
		end else begin
			comm_o <= read_word;
		end
	end

	assign stall_o = full_i & (record_i == REC_EVICT); // masked on other records

endmodule

// ==== design/cache_perf_monitor.sv ====
module cache_perf_monitor (
	input  logic        clock_i,
	input  logic        resetn_i,
	input  logic [31:0] comm_i,
	input  logic        req_i,
	input  logic        hit_i,
	input  logic        miss_i,
	input  logic        writeback_i,
	input  logic        expired_i,
	input  logic        expired_multi_i,
	input  logic        defaulted_i,
	input  logic        rand_evict_i,
	output logic [31:0] comm_o,
	output logic        stall_o
);
	import cache_event_pkg::*;
	import perf_map_pkg::*;

	logic          count_en;
	logic          track_en;
	logic          pop;
	record_sel_t   record;
	read_addr_t    addr;

	event_count_t  hits, misses, writebacks, cycles;
	event_count_t  expired_cnt, multi_expired_cnt, defaulted_cnt;
	event_count_t  default_misses, rand_evict_cnt;
	ref_stamp_t    ref_stamp;

	evict_status_t head_status;
	ref_stamp_t    head_stamp;
	trace_count_t  trace_count;
	logic          trace_full;

	perf_control u_control (
		.clock_i    (clock_i),
		.resetn_i   (resetn_i),
		.comm_i     (comm_i),
		.count_en_o (count_en),
		.track_en_o (track_en),
		.pop_o      (pop),
		.record_o   (record),
		.addr_o     (addr)
	);

	event_counters u_counters (
		.clock_i          (clock_i),
		.resetn_i         (resetn_i),
		.count_en_i       (count_en),
		.req_i            (req_i),
		.hit_i            (hit_i),
		.miss_i           (miss_i),
		.writeback_i      (writeback_i),
		.expired_i        (expired_i),
		.expired_multi_i  (expired_multi_i),
		.defaulted_i      (defaulted_i),
		.rand_evict_i     (rand_evict_i),
		.hits_o           (hits),
		.misses_o         (misses),
		.writebacks_o     (writebacks),
		.cycles_o         (cycles),
		.expired_o        (expired_cnt),
		.multi_expired_o  (multi_expired_cnt),
		.defaulted_o      (defaulted_cnt),
		.default_misses_o (default_misses),
		.rand_evict_o     (rand_evict_cnt),
		.ref_stamp_o      (ref_stamp)
	);

	eviction_tracker u_tracker (
		.clock_i         (clock_i),
		.resetn_i        (resetn_i),
		.track_en_i      (track_en),
		.pop_i           (pop),
		.expired_i       (expired_i),
		.expired_multi_i (expired_multi_i),
		.rand_evict_i    (rand_evict_i),
		.ref_stamp_i     (ref_stamp),
		.head_status_o   (head_status),
		.head_stamp_o    (head_stamp),
		.count_o         (trace_count),
		.full_o          (trace_full)
	);

	perf_readout u_readout (
		.clock_i          (clock_i),
		.resetn_i         (resetn_i),
		.record_i         (record),
		.addr_i           (addr),
		.hits_i           (hits),
		.misses_i         (misses),
		.writebacks_i     (writebacks),
		.cycles_i         (cycles),
		.expired_i        (expired_cnt),
		.multi_expired_i  (multi_expired_cnt),
		.defaulted_i      (defaulted_cnt),
		.default_misses_i (default_misses),
		.rand_evict_i     (rand_evict_cnt),
		.head_status_i    (head_status),
		.head_stamp_i     (head_stamp),
		.count_i          (trace_count),
		.full_i           (trace_full),
		.comm_o           (comm_o),
		.stall_o          (stall_o)
	);

endmodule

// ==== test/cache_perf_monitor_props.sv ====
module cache_perf_monitor_props (
	input  logic        clock_i,
	input  logic        resetn_i,
	input  logic [31:0] comm_i,       // configuration word of the monitor
	input  logic [31:0] read_data_i,  // comm_o of the monitor
	input  logic        stall_i,
	input  logic        pop_i
);
	import perf_map_pkg::*;

	int assert_fails;                   // failed assertions so far

	// outputs come out of reset low
	reset_low: assert property (@(posedge clock_i) !resetn_i |=> (read_data_i == '0) && !stall_i)
		else begin
			$error("comm_o or stall_o not low in the cycle after reset");
			assert_fails++;
		end

	// record as configured at the previous edge
	stall_record: assert property (@(posedge clock_i) disable iff (!resetn_i)
		stall_i |-> $past(comm_i[COMM_REC_HI:COMM_REC_LO]) == REC_EVICT)
		else begin
			$error("stall_o high while the eviction record is not selected");
			assert_fails++;
		end

	pop_single: assert property (@(posedge clock_i) disable iff (!resetn_i) pop_i |=> !pop_i)
		else begin
			$error("pop pulse lasted two cycles");
			assert_fails++;
		end

endmodule

bind cache_perf_monitor cache_perf_monitor_props u_props (
	.clock_i     (clock_i),
	.resetn_i    (resetn_i),
	.comm_i      (comm_i),
	.read_data_i (comm_o),
	.stall_i     (stall_o),
	.pop_i       (pop)
);

// ==== test/cache_perf_monitor_tb.sv ====
module cache_perf_monitor_tb;
	import perf_map_pkg::*;

	localparam logic [31:0] CNT_EN = 32'h0100_0000;  // comm bit 24
	localparam logic [31:0] POP    = 32'h0200_0000;  // comm bit 25
	localparam logic [31:0] EV_REC = 32'h0400_0000;  // record 1
	localparam logic [31:0] RES2   = 32'h0800_0000;  // record 2
	localparam logic [31:0] RES3   = 32'h0c00_0000;  // record 3
	// strobe vector: req hit miss wb expired multi defaulted rand
	localparam logic [7:0] S_REQ = 8'h80, S_HIT = 8'h40, S_EXP = 8'h08;
	localparam logic [7:0] S_MULTI = 8'h04, S_RAND = 8'h01;
	localparam int CHK_MODEL = 1, CHK_FIXED = 2;

	typedef struct {
		logic [31:0] comm;
		logic [7:0]  strobes;
		bit          rand_en;    // strobes from the xorshift generator
		int          cycles;
		int          check;
		logic [31:0] exp_word;   // used on the last cycle of a fixed check
	} row_t;

	logic        clock_i, resetn_i, req_i, hit_i, miss_i, writeback_i;
	logic        expired_i, expired_multi_i, defaulted_i, rand_evict_i;
	logic [31:0] comm_i, comm_o;
	logic        stall_o;

	row_t        rows[$];
	logic [31:0] rng_state;
	int          errors, checks, cycle_count, cycle_limit;

	// reference model
	logic        m_cnt_en, m_trk_en, m_pop, m_pop_bit;
	logic [1:0]  m_rec;
	logic [4:0]  m_addr;
	logic [63:0] m_cnt [9];  // hits misses wb cycles expired defaulted multi def_miss rand
	logic [47:0] m_ref;
	logic [49:0] m_trace[$]; // status and stamp per entry
	logic [31:0] exp_comm;
	logic        exp_stall;

	cache_perf_monitor DUT (
		.clock_i(clock_i), .resetn_i(resetn_i), .comm_i(comm_i), .req_i(req_i),
		.hit_i(hit_i), .miss_i(miss_i), .writeback_i(writeback_i), .expired_i(expired_i),
		.expired_multi_i(expired_multi_i), .defaulted_i(defaulted_i),
		.rand_evict_i(rand_evict_i), .comm_o(comm_o), .stall_o(stall_o)
	);

	always #10 clock_i = ~clock_i;

	always @(posedge clock_i) begin
		cycle_count = cycle_count + 1;
		if (cycle_limit > 0 && cycle_count > cycle_limit) begin
			$display("timeout: run did not finish within %0d cycles", cycle_limit);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	// multi beats random, random beats single
	function automatic logic [1:0] evict_code(input logic [7:0] s);
		if (s[2]) return 2'b10;
		if (s[0]) return 2'b11;
		return 2'b01;
	endfunction

	function logic [31:0] model_word();
		logic [49:0] head;
		logic [63:0] cnt;
		head = (m_trace.size() > 0) ? m_trace[0] : '0;
		if (m_rec == 2'd0) begin
			if (m_addr == 5'd15) return CACHE_ID;
			if (m_addr == 5'd14 || m_addr > 5'd19) return 32'h0;
			cnt = (m_addr < 5'd14) ? m_cnt[m_addr / 2] : m_cnt[m_addr / 2 - 1];
			return m_addr[0] ? cnt[63:32] : cnt[31:0];
		end else if (m_rec == 2'd1) begin
			case (m_addr)
				5'd0: return {20'd0, 4'(m_trace.size()), 6'd0, head[49:48]};
				5'd1: return head[31:0];
				5'd2: return {16'd0, head[47:32]};
				5'd3: return {31'd0, m_trace.size() == 8};
				default: return 32'h0;
			endcase
		end
		return 32'h0;
	endfunction

	task reset_model();
		m_cnt_en = 0;
		m_trk_en = 0;
		m_pop = 0;
		m_pop_bit = 0;
		m_rec = 0;
		m_addr = 0;
		m_ref = 0;
		foreach (m_cnt[i]) m_cnt[i] = '0;
		m_trace.delete();
	endtask

	// one clock edge of the model, using the inputs the DUT samples now
	task model_edge();
		logic [7:0] s;
		logic       push, pop;
		s = {req_i, hit_i, miss_i, writeback_i, expired_i, expired_multi_i, defaulted_i,
			rand_evict_i};
		exp_comm = model_word();                        // comm_o lags by one edge
		pop  = m_pop && m_trace.size() > 0;
		push = m_trk_en && (s & (S_EXP | S_MULTI | S_RAND)) != 0 && m_trace.size() < 8;
		if (pop) void'(m_trace.pop_front());
		if (push) m_trace.push_back({evict_code(s), m_ref}); // stamp before the increment
		if (m_cnt_en) begin
			m_cnt[3] = m_cnt[3] + 1;
			if (s[7]) m_ref = m_ref + 1;
			if (s[6]) m_cnt[0] = m_cnt[0] + 1;
			if (s[5]) m_cnt[1] = m_cnt[1] + 1;
			if (s[4]) m_cnt[2] = m_cnt[2] + 1;
			if (s[3]) m_cnt[4] = m_cnt[4] + 1;
			if (s[1]) m_cnt[5] = m_cnt[5] + 1;
			if (s[2]) m_cnt[6] = m_cnt[6] + 1;
			if (s[5] && s[1]) m_cnt[7] = m_cnt[7] + 1;
			if (s[0]) m_cnt[8] = m_cnt[8] + 1;
		end
		m_cnt_en  = comm_i[24];
		m_rec     = (comm_i[27:26] > 2'd1) ? 2'd2 : comm_i[27:26];
		m_trk_en  = (m_rec == 2'd1);
		m_pop     = comm_i[25] & ~m_pop_bit;
		m_pop_bit = comm_i[25];
		m_addr    = comm_i[4:0];
		exp_stall = (m_trace.size() == 8) && (m_rec == 2'd1);
	endtask

	task add_row(input logic [31:0] comm, input logic [7:0] strobes, input bit rand_en,
			input int cycles, input int check, input logic [31:0] exp_word);
		row_t r;
		r = '{comm, strobes, rand_en, cycles, check, exp_word};
		rows.push_back(r);
	endtask

	task drive_inputs(input logic [31:0] comm, input logic [7:0] s);
		comm_i <= comm;
		{req_i, hit_i, miss_i, writeback_i, expired_i, expired_multi_i, defaulted_i,
			rand_evict_i} <= s;
	endtask

	task build_table();
		read_addr_t res_addr [3];
		res_addr = '{5'd0, 5'd3, 5'd15};
		for (int a = 0; a < 20; a++) begin
			add_row(a, 0, 0, 3, CHK_FIXED, (a == 15) ? CACHE_ID : 0);
		end
		for (int a = 0; a < 20; a++) add_row(CNT_EN | a, 0, 1, 4, CHK_MODEL, 0);
		for (int a = 0; a < 20; a++) add_row(a, 0, 1, 3, CHK_MODEL, 0); // counting off
		add_row(EV_REC | CNT_EN, S_REQ, 0, 3, CHK_MODEL, 0);
		add_row(EV_REC | CNT_EN, S_REQ | S_EXP, 0, 1, CHK_MODEL, 0);
		add_row(EV_REC | CNT_EN, S_REQ, 0, 2, CHK_MODEL, 0);
		add_row(EV_REC | CNT_EN, S_REQ | S_EXP | S_MULTI, 0, 1, CHK_MODEL, 0);
		add_row(EV_REC | CNT_EN, S_REQ | S_RAND, 0, 1, CHK_MODEL, 0);
		add_row(EV_REC | CNT_EN, S_REQ | S_EXP | S_RAND, 0, 1, CHK_MODEL, 0);
		add_row(EV_REC | CNT_EN, S_MULTI | S_RAND, 0, 1, CHK_MODEL, 0);
		add_row(EV_REC | CNT_EN, 0, 0, 2, CHK_MODEL, 0);
		add_row(EV_REC | CNT_EN, 0, 0, 3, CHK_FIXED, 32'h0000_0501); // five held, single
		for (int i = 0; i < 5; i++) begin
			for (int a = 0; a < 3; a++) add_row(EV_REC | CNT_EN | a, 0, 0, 3, CHK_MODEL, 0);
			add_row(EV_REC | CNT_EN | POP, 0, 0, 2, CHK_MODEL, 0);
			add_row(EV_REC | CNT_EN, 0, 0, 2, CHK_MODEL, 0);
		end
		add_row(EV_REC | CNT_EN, S_REQ | S_EXP, 0, 9, CHK_MODEL, 0); // ninth one is lost
		add_row(EV_REC | CNT_EN | 3, 0, 0, 3, CHK_FIXED, 32'h1);
		add_row(EV_REC | CNT_EN, 0, 0, 3, CHK_FIXED, 32'h0000_0801);
		add_row(EV_REC | CNT_EN | POP, 0, 0, 2, CHK_MODEL, 0);
		add_row(EV_REC | CNT_EN, 0, 0, 3, CHK_MODEL, 0);
		add_row(EV_REC | CNT_EN, S_REQ | S_RAND, 0, 1, CHK_MODEL, 0);
		add_row(EV_REC | CNT_EN, 0, 0, 2, CHK_MODEL, 0);
		add_row(CNT_EN, 0, 0, 3, CHK_MODEL, 0);                      // stall masked
		foreach (res_addr[i]) begin
			add_row(RES2 | res_addr[i], S_REQ | S_HIT, 0, 3, CHK_FIXED, 0);
			add_row(RES3 | res_addr[i], S_REQ | S_HIT, 0, 3, CHK_FIXED, 0);
		end
		add_row(CNT_EN | 14, 0, 0, 3, CHK_FIXED, 0);
		add_row(CNT_EN | 20, 0, 0, 3, CHK_FIXED, 0);
		add_row(CNT_EN | 31, 0, 0, 3, CHK_FIXED, 0);
		add_row(EV_REC | 4, 0, 0, 3, CHK_FIXED, 0);
		add_row(EV_REC | 31, 0, 0, 3, CHK_FIXED, 0);
	endtask

	initial begin
		logic [7:0] s;
		int         total;
		clock_i = 0;
		resetn_i = 0;
		comm_i = 0;
		{req_i, hit_i, miss_i, writeback_i, expired_i, expired_multi_i, defaulted_i,
			rand_evict_i} = '0;
		rng_state = 32'h7f8a;
		errors = 0;
		checks = 0;
		cycle_count = 0;
		total = 0;
		reset_model();
		build_table();
		foreach (rows[r]) total += rows[r].cycles;
		cycle_limit = total + 8 + 100;                  // table length plus margin
		repeat (8) @(posedge clock_i);
		resetn_i <= 1'b1;
		foreach (rows[r]) begin
			for (int n = 0; n < rows[r].cycles; n++) begin
				@(posedge clock_i);
				model_edge();
				s = rows[r].strobes;
				if (rows[r].rand_en) begin
					rng_state = xorshift(rng_state);
					s = rng_state[7:0];
				end
				drive_inputs(rows[r].comm, s);
				@(negedge clock_i);
				if (rows[r].check == CHK_MODEL) begin
					checks++;
					if (comm_o !== exp_comm) begin
						errors++;
						$display("FAIL %0t: row %0d comm_o %h expected %h", $time, r,
							comm_o, exp_comm);
					end
				end
				if (rows[r].check == CHK_FIXED && n == rows[r].cycles - 1) begin
					checks++;
					if (comm_o !== rows[r].exp_word) begin
						errors++;
						$display("FAIL %0t: row %0d comm_o %h expected %h", $time, r, comm_o,
							rows[r].exp_word);
					end
				end
				checks++;
				if (stall_o !== exp_stall) begin
					errors++;
					$display("FAIL %0t: row %0d stall_o %b expected %b", $time, r,
						stall_o, exp_stall);
				end
			end
		end
		$display("checks %0d errors %0d assertion failures %0d", checks, errors,
			DUT.u_props.assert_fails);
		if (errors == 0 && DUT.u_props.assert_fails == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

// ==== cache_perf_monitor.f ====
design/cache_event_pkg.sv
design/perf_map_pkg.sv
design/perf_control.sv
design/event_counters.sv
design/eviction_tracker.sv
design/perf_readout.sv
design/cache_perf_monitor.sv
test/cache_perf_monitor_props.sv
test/cache_perf_monitor_tb.sv
